//--- tb.f
verilog/uart_string_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/string_framer.sv
verilog/string_deframer.sv
verilog/uart_string_top.sv
dv/tb_uart_string.sv

//--- Bender.yml
package:
  name: uart_string

sources:
  - verilog/uart_string_pkg.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/string_framer.sv
  - verilog/string_deframer.sv
  - verilog/uart_string_top.sv
  - target: test
    files:
      - dv/tb_uart_string.sv

//--- dv/tb_uart_string.sv
/*
 * Testbench for the UART string link.
 * A serial decoder watches uart_tx_port, a serial driver or the loopback
 * feeds uart_rx_port, and assertions compare against expected frames.
 */
`default_nettype none

module tb_uart_string;
	import uart_string_pkg::*;

	localparam int CLK_FREQ = 8_000_000;
	localparam int BAUD_RATE = 1_000_000;
	localparam int MAX_LEN = 16;
	localparam int TIMEOUT_BITS = 20;
	localparam int CPB = CLK_FREQ / BAUD_RATE;
	localparam int LEN_W = $clog2(MAX_LEN) + 1;

	// serial bytes per test in order 1 to 6, idle gap of test 5 included
	localparam int RUN_BYTES = 224 + 43 + 13 + 27 + 16 + 12;
	localparam int CYCLE_LIMIT = RUN_BYTES * 90 + 5000;

	typedef logic [MAX_LEN*8-1:0] str_t;
	typedef logic [LEN_W-1:0] len_t;

	logic sys_clk = 1'b0;
	logic sys_rst_n = 1'b0;
	str_t tx_string = '0;
	len_t tx_length = '0;
	logic tx_req = 1'b0;
	logic tx_busy;
	logic tx_done;
	str_t rx_string;
	len_t rx_length;
	logic rx_busy;
	logic rx_done;
	logic rx_err;
	logic uart_tx_port;
	logic drv_line = 1'b1;
	logic loopback = 1'b0;
	wire rx_line;

	// expected transmit stream, appended per string
	byte_t exp_tx [0:511];
	int exp_tx_n = 0;
	str_t exp_rx_str = '0;
	len_t exp_rx_len = '0;
	logic rx_expect = 1'b0;
	logic err_expect = 1'b0;

	logic dec_vld = 1'b0;
	logic dec_stop = 1'b1;
	byte_t dec_byte = '0;
	int dec_idx = 0;

	int tx_done_cnt = 0;
	int rx_done_cnt = 0;
	int rx_err_cnt = 0;
	int error_cnt = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;
	logic [31:0] rng_state = 32'd41767;
	int loop_lens [4] = '{3, 16, 7, 1};

	assign rx_line = loopback ? uart_tx_port : drv_line;

	always #4 sys_clk = ~sys_clk;

	uart_string_top #(
		.CLK_FREQ(CLK_FREQ),
		.BAUD_RATE(BAUD_RATE),
		.MAX_LEN(MAX_LEN),
		.TIMEOUT_BITS(TIMEOUT_BITS)
	) uut (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_string(tx_string),
		.tx_length(tx_length),
		.tx_req(tx_req),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_string(rx_string),
		.rx_length(rx_length),
		.rx_busy(rx_busy),
		.rx_done(rx_done),
		.rx_err(rx_err),
		.uart_rx_port(rx_line),
		.uart_tx_port(uart_tx_port)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// random payload byte, never the delimiter
	function automatic byte_t rand_char();
		byte_t c;
		rng_state = xorshift32(rng_state);
		c = rng_state[7:0];
		if (c == DELIM_CHAR)
			c = 8'h5f;
		return c;
	endfunction

	function automatic str_t random_string(input int len);
		str_t v;
		v = '0;
		for (int i = 0; i < len; i++)
			v[i*8 +: 8] = rand_char();
		return v;
	endfunction

	// first character lands in byte 0
	function automatic str_t pack_text(input string s);
		str_t v;
		v = '0;
		for (int i = 0; i < s.len(); i++)
			v[i*8 +: 8] = s[i];
		return v;
	endfunction

	task automatic expect_equal(input string name, input str_t exp, input str_t act);
		assert (act === exp)
		else begin
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			error_cnt++;
		end
	endtask

	task automatic send_byte(input byte_t b);
		drv_line <= 1'b0;
		repeat (CPB) @(posedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			drv_line <= b[i];
			repeat (CPB) @(posedge sys_clk);
		end
		drv_line <= 1'b1;
		repeat (CPB) @(posedge sys_clk);
	endtask

	task automatic send_text(input string s);
		for (int i = 0; i < s.len(); i++)
			send_byte(s[i]);
	endtask

	task automatic send_frame(input str_t s, input int len);
		for (int i = 0; i < DELIM_COUNT; i++)
			send_byte(DELIM_CHAR);
		for (int i = 0; i < len; i++)
			send_byte(s[i*8 +: 8]);
		for (int i = 0; i < DELIM_COUNT; i++)
			send_byte(DELIM_CHAR);
	endtask

	task automatic request_string(input str_t s, input int len);
		tx_string <= s;
		tx_length <= len_t'(len);
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	// what the line should carry, oversize lengths clipped
	task automatic expect_tx(input str_t s, input int len);
		int n;
		n = (len > MAX_LEN) ? MAX_LEN : len;
		for (int i = 0; i < n + 2 * DELIM_COUNT; i++) begin
			if (i < DELIM_COUNT || i >= n + DELIM_COUNT)
				exp_tx[exp_tx_n] = DELIM_CHAR;
			else
				exp_tx[exp_tx_n] = s[(i - DELIM_COUNT)*8 +: 8];
			exp_tx_n++;
		end
	endtask

	task automatic transmit_string(input str_t s, input int len);
		int base;
		base = tx_done_cnt;
		expect_tx(s, len);
		request_string(s, len);
		while (tx_done_cnt < base + 1)
			@(posedge sys_clk);
		repeat (2 * CPB) @(posedge sys_clk);
		expect_equal("tx_done count", base + 1, tx_done_cnt);
		expect_equal("decoded byte count", exp_tx_n, dec_idx);
	endtask

	task automatic wait_rx_done(input int target);
		while (rx_done_cnt < target)
			@(posedge sys_clk);
		repeat (CPB) @(posedge sys_clk);
		expect_equal("rx_done count", target, rx_done_cnt);
	endtask

	task automatic finish_test(input int num, input string name, input int errs_before);
		if (error_cnt == errs_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, error_cnt - errs_before);
			tests_failed++;
		end
	endtask

	// serial decoder, mid-bit sampling of the transmit line
	initial begin : serial_decoder
		byte_t b;
		forever begin
			@(posedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (CPB / 2) @(posedge sys_clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CPB) @(posedge sys_clk);
					b[i] = uart_tx_port;
				end
				repeat (CPB) @(posedge sys_clk);
				dec_stop <= uart_tx_port;
				dec_byte <= b;
				dec_vld <= 1'b1;
				@(posedge sys_clk);
				dec_vld <= 1'b0;
				dec_idx <= dec_idx + 1;
			end
		end
	end

	always @(posedge sys_clk) begin
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
		if (rx_err)
			rx_err_cnt <= rx_err_cnt + 1;
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	a_dec_byte: assert property (@(posedge sys_clk) dec_vld |-> dec_byte == exp_tx[dec_idx])
	else begin
		$display("FAILED at %0t: uart_tx_port byte %0d expected %h, got %h", $time,
			$sampled(dec_idx), exp_tx[$sampled(dec_idx)], $sampled(dec_byte));
		error_cnt++;
	end

	a_dec_extra: assert property (@(posedge sys_clk) dec_vld |-> dec_idx < exp_tx_n)
	else begin
		$display("uart_tx_port carried a byte beyond the expected frames at %0t", $time);
		error_cnt++;
	end

	a_dec_stop: assert property (@(posedge sys_clk) dec_vld |-> dec_stop)
	else begin
		$display("uart_tx_port stop bit was low at %0t", $time);
		error_cnt++;
	end

	a_line_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) !uart_tx_port |-> tx_busy)
	else begin
		$display("FAILED at %0t: tx_busy expected 1, got 0", $time);
		error_cnt++;
	end

	a_rx_done_allowed: assert property (@(posedge sys_clk) rx_done |-> rx_expect)
	else begin
		$display("rx_done pulsed at %0t where no frame should complete", $time);
		error_cnt++;
	end

	a_rx_length: assert property (@(posedge sys_clk) rx_done |-> rx_length == exp_rx_len)
	else begin
		$display("FAILED at %0t: rx_length expected %0d, got %0d", $time,
			exp_rx_len, $sampled(rx_length));
		error_cnt++;
	end

	a_rx_string: assert property (@(posedge sys_clk) rx_done |-> rx_string == exp_rx_str)
	else begin
		$display("FAILED at %0t: rx_string expected %h, got %h", $time,
			exp_rx_str, $sampled(rx_string));
		error_cnt++;
	end

	a_rx_err_allowed: assert property (@(posedge sys_clk) rx_err |-> err_expect)
	else begin
		$display("rx_err pulsed at %0t without an oversize frame", $time);
		error_cnt++;
	end

	initial begin : main_sequence
		str_t s;
		int base;
		int base_err;
		int errs;
		errs = error_cnt;
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		expect_equal("uart_tx_port", 1, uart_tx_port);
		expect_equal("tx_busy", 0, tx_busy);
		expect_equal("tx_done", 0, tx_done);
		expect_equal("rx_busy", 0, rx_busy);
		expect_equal("rx_done", 0, rx_done);
		expect_equal("rx_err", 0, rx_err);
		expect_equal("rx_string", 0, rx_string);
		expect_equal("rx_length", 0, rx_length);
		for (int len = 0; len <= MAX_LEN; len++)
			transmit_string(random_string(len), len);
		// length 20 goes out clipped to capacity
		transmit_string(random_string(MAX_LEN), 20);
		finish_test(1, "transmit format", errs);

		errs = error_cnt;
		loopback <= 1'b1;
		@(posedge sys_clk);
		rx_expect = 1'b1;
		for (int k = 0; k < 4; k++) begin
			s = random_string(loop_lens[k]);
			exp_rx_str = s;
			exp_rx_len = len_t'(loop_lens[k]);
			base = rx_done_cnt;
			transmit_string(s, loop_lens[k]);
			wait_rx_done(base + 1);
		end
		rx_expect = 1'b0;
		loopback <= 1'b0;
		@(posedge sys_clk);
		finish_test(2, "loopback round trip", errs);

		errs = error_cnt;
		base = rx_done_cnt;
		send_text("xy&z");
		repeat (CPB) @(posedge sys_clk);
		exp_rx_str = pack_text("ab&cd");
		exp_rx_len = 5;
		rx_expect = 1'b1;
		send_frame(exp_rx_str, 5);
		wait_rx_done(base + 1);
		rx_expect = 1'b0;
		finish_test(3, "hunting and lone delimiter", errs);

		errs = error_cnt;
		base_err = rx_err_cnt;
		err_expect = 1'b1;
		for (int i = 0; i < DELIM_COUNT; i++)
			send_byte(DELIM_CHAR);
		for (int i = 0; i <= MAX_LEN; i++)
			send_byte(rand_char());
		repeat (CPB) @(posedge sys_clk);
		err_expect = 1'b0;
		expect_equal("rx_err count", base_err + 1, rx_err_cnt);
		s = random_string(4);
		exp_rx_str = s;
		exp_rx_len = 4;
		rx_expect = 1'b1;
		base = rx_done_cnt;
		send_frame(s, 4);
		wait_rx_done(base + 1);
		rx_expect = 1'b0;
		finish_test(4, "overflow", errs);

		errs = error_cnt;
		base = rx_done_cnt;
		send_text("&&abc");
		expect_equal("rx_busy", 1, rx_busy);
		repeat ((TIMEOUT_BITS + 5) * CPB) @(posedge sys_clk);
		expect_equal("rx_busy", 0, rx_busy);
		expect_equal("rx_done count", base, rx_done_cnt);
		s = random_string(4);
		exp_rx_str = s;
		exp_rx_len = 4;
		rx_expect = 1'b1;
		send_frame(s, 4);
		wait_rx_done(base + 1);
		rx_expect = 1'b0;
		finish_test(5, "timeout", errs);

		errs = error_cnt;
		base = tx_done_cnt;
		s = random_string(6);
		expect_tx(s, 6);
		request_string(s, 6);
		repeat (3 * CPB) @(posedge sys_clk);
		// second request lands while the first frame is on the line
		request_string(random_string(4), 4);
		while (tx_done_cnt < base + 1)
			@(posedge sys_clk);
		repeat (12 * CPB) @(posedge sys_clk);
		expect_equal("tx_done count", base + 1, tx_done_cnt);
		expect_equal("decoded byte count", exp_tx_n, dec_idx);
		expect_equal("tx_busy", 0, tx_busy);
		finish_test(6, "request while busy", errs);

		$display("tests run: 6, tests failed: %0d, errors: %0d", tests_failed, error_cnt);
		if (error_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/uart_string_top.sv
/*
 * UART string link top level.
 * Transmit path is framer into uart_tx, receive path is uart_rx into
 * the deframer. The two directions run independently.
 */
`default_nettype none

module uart_string_top #(
	parameter int CLK_FREQ = uart_string_pkg::DEF_CLK_FREQ,
	parameter int BAUD_RATE = uart_string_pkg::DEF_BAUD_RATE,
	parameter int MAX_LEN = uart_string_pkg::DEF_MAX_LEN,
	parameter int TIMEOUT_BITS = uart_string_pkg::DEF_TIMEOUT_BITS
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [MAX_LEN*8-1:0] tx_string,
	input wire [$clog2(MAX_LEN):0] tx_length,
	input wire tx_req,
	output logic tx_busy,
	output logic tx_done,
	output logic [MAX_LEN*8-1:0] rx_string,
	output logic [$clog2(MAX_LEN):0] rx_length,
	output logic rx_busy,
	output logic rx_done,
	output logic rx_err,
	input wire uart_rx_port,
	output logic uart_tx_port
);
	import uart_string_pkg::*;

	// framer to transmitter
	logic tx_byte_req;
	logic tx_byte_done;
	byte_t tx_byte_data;

	// receiver to deframer
	logic rx_byte_vld;
	byte_t rx_byte;

	string_framer #(
		.MAX_LEN(MAX_LEN)
	) u_framer (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_string(tx_string),
		.tx_length(tx_length),
		.tx_req(tx_req),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.byte_req(tx_byte_req),
		.byte_data(tx_byte_data),
		.byte_done(tx_byte_done)
	);

	uart_tx #(
		.CLK_FREQ(CLK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) u_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.byte_req(tx_byte_req),
		.byte_data(tx_byte_data),
		.byte_done(tx_byte_done),
		.tx(uart_tx_port)
	);

	uart_rx #(
		.CLK_FREQ(CLK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) u_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.rx(uart_rx_port),
		.rx_byte(rx_byte),
		.rx_byte_vld(rx_byte_vld)
	);

	string_deframer #(
		.CLK_FREQ(CLK_FREQ),
		.BAUD_RATE(BAUD_RATE),
		.MAX_LEN(MAX_LEN),
		.TIMEOUT_BITS(TIMEOUT_BITS)
	) u_deframer (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.rx_byte(rx_byte),
		.rx_byte_vld(rx_byte_vld),
		.rx_string(rx_string),
		.rx_length(rx_length),
		.rx_busy(rx_busy),
		.rx_done(rx_done),
		.rx_err(rx_err)
	);

endmodule

`default_nettype wire

//--- verilog/string_deframer.sv
/*
 * Receive side string deframer.
 * Hunts for the opening "&&", collects payload into a working buffer and
 * hands it out with rx_done when the closing "&&" arrives. Oversize frames
 * pulse rx_err, idle frames are dropped quietly after TIMEOUT_BITS.
 */
`default_nettype none

module string_deframer #(
	parameter int CLK_FREQ = uart_string_pkg::DEF_CLK_FREQ,
	parameter int BAUD_RATE = uart_string_pkg::DEF_BAUD_RATE,
	parameter int MAX_LEN = uart_string_pkg::DEF_MAX_LEN,
	parameter int TIMEOUT_BITS = uart_string_pkg::DEF_TIMEOUT_BITS
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire uart_string_pkg::byte_t rx_byte,
	input wire rx_byte_vld,
	output logic [MAX_LEN*8-1:0] rx_string,
	output logic [$clog2(MAX_LEN):0] rx_length,
	output logic rx_busy,
	output logic rx_done,
	output logic rx_err
);
	import uart_string_pkg::*;

	localparam int LEN_W = $clog2(MAX_LEN) + 1;
	localparam int DCNT_W = $clog2(DELIM_COUNT + 1);
	localparam int TIMEOUT_CLKS = TIMEOUT_BITS * (CLK_FREQ / BAUD_RATE);
	localparam int IDLE_W = $clog2(TIMEOUT_CLKS + 1);

	typedef enum logic [2:0] {S_HUNT, S_OPEN, S_CONTENT, S_PEND, S_FINISH} state_t;

	state_t state;
	logic [MAX_LEN*8-1:0] work;
	logic [LEN_W-1:0] len;
	logic [DCNT_W-1:0] delim_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic is_delim;
	logic last_delim;
	logic in_frame;
	logic open_done;
	logic store_one;
	logic store_pair;
	logic timeout;

	assign is_delim = (rx_byte == DELIM_CHAR);
	assign last_delim = (delim_cnt == DCNT_W'(DELIM_COUNT - 1));
	assign in_frame = (state == S_OPEN) || (state == S_CONTENT) || (state == S_PEND);
	assign open_done = rx_byte_vld && (state == S_OPEN) && is_delim && last_delim;
	assign store_one = rx_byte_vld && (state == S_CONTENT) && !is_delim &&
		(int'(len) < MAX_LEN);
	// lone delimiter plus the byte after it
	assign store_pair = rx_byte_vld && (state == S_PEND) && !is_delim &&
		(int'(len) + 2 <= MAX_LEN);
	assign timeout = in_frame && (idle_cnt == IDLE_W'(TIMEOUT_CLKS - 1));

	assign rx_busy = (state == S_CONTENT) || (state == S_PEND);
	assign rx_done = (state == S_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_HUNT;
			len <= '0;
			delim_cnt <= '0;
			rx_string <= '0;
			rx_length <= '0;
			rx_err <= 1'b0;
		end else begin
			rx_err <= 1'b0;
			case (state)
				S_HUNT: begin
					if (rx_byte_vld && is_delim) begin
						state <= S_OPEN;
						delim_cnt <= DCNT_W'(1);
					end
				end
				S_OPEN: begin
					if (open_done) begin
						state <= S_CONTENT;
						len <= '0;
					end else if (rx_byte_vld) begin
						if (is_delim)
							delim_cnt <= delim_cnt + DCNT_W'(1);
						else
							state <= S_HUNT;
					end else if (timeout) begin
						state <= S_HUNT;
					end
				end
				S_CONTENT: begin
					if (rx_byte_vld) begin
						if (is_delim) begin
							state <= S_PEND;
							delim_cnt <= DCNT_W'(1);
						end else if (store_one) begin
							len <= len + LEN_W'(1);
						end else begin
							state <= S_HUNT;
							rx_err <= 1'b1;
						end
					end else if (timeout) begin
						state <= S_HUNT;
					end
				end
				S_PEND: begin
					if (rx_byte_vld) begin
						if (is_delim && last_delim) begin
							// closing pair complete
							state <= S_FINISH;
							rx_string <= work;
							rx_length <= len;
						end else if (is_delim) begin
							delim_cnt <= delim_cnt + DCNT_W'(1);
						end else if (store_pair) begin
							state <= S_CONTENT;
							len <= len + LEN_W'(2);
						end else begin
							state <= S_HUNT;
							rx_err <= 1'b1;
						end
					end else if (timeout) begin
						state <= S_HUNT;
					end
				end
				default: begin
					state <= S_HUNT;
				end
			endcase
		end
	end

	// idle gap counter, restarts on every byte
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			idle_cnt <= '0;
		else if (!in_frame || rx_byte_vld || timeout)
			idle_cnt <= '0;
		else
			idle_cnt <= idle_cnt + IDLE_W'(1);
	end

	// working buffer is zeroed at frame start so unused bytes read as zero
	always_ff @(posedge sys_clk) begin
		if (open_done) begin
			work <= '0;
		end else if (store_one) begin
			work[len * 8 +: 8] <= rx_byte;
		end else if (store_pair) begin
			work[len * 8 +: 8] <= DELIM_CHAR;
			work[(len + LEN_W'(1)) * 8 +: 8] <= rx_byte;
		end
	end

	a_done_err_exclusive: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_err)
	) else $error("string_deframer: rx_done and rx_err together");

endmodule

`default_nettype wire

//--- verilog/string_framer.sv
/*
 * Transmit side string framer.
 * Latches a string on an accepted tx_req and feeds uart_tx one byte at a
 * time as "&&", payload, "&&". tx_busy covers the whole frame and tx_done
 * pulses once the last delimiter has left the transmitter.
 */
`default_nettype none

module string_framer #(
	parameter int MAX_LEN = uart_string_pkg::DEF_MAX_LEN
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [MAX_LEN*8-1:0] tx_string,
	input wire [$clog2(MAX_LEN):0] tx_length,
	input wire tx_req,
	output logic tx_busy,
	output logic tx_done,
	output logic byte_req,
	output uart_string_pkg::byte_t byte_data,
	input wire byte_done
);
	import uart_string_pkg::*;

	localparam int LEN_W = $clog2(MAX_LEN) + 1;
	localparam int DCNT_W = $clog2(DELIM_COUNT + 1);

	typedef enum logic [1:0] {S_IDLE, S_OPEN, S_CONTENT, S_CLOSE} state_t;

	state_t state;
	logic [MAX_LEN*8-1:0] str_buf;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] byte_cnt;
	logic [DCNT_W-1:0] delim_cnt;
	logic accept;
	logic last_delim;

	assign accept = tx_req && (state == S_IDLE);
	assign last_delim = (delim_cnt == DCNT_W'(DELIM_COUNT - 1));
	assign tx_busy = (state != S_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= S_IDLE;
			len_q <= '0;
			byte_cnt <= '0;
			delim_cnt <= '0;
			byte_req <= 1'b0;
			byte_data <= '0;
			tx_done <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_OPEN;
						// oversize lengths are clipped to capacity
						len_q <= (tx_length > LEN_W'(MAX_LEN)) ? LEN_W'(MAX_LEN) : tx_length;
						delim_cnt <= '0;
						byte_req <= 1'b1;
						byte_data <= DELIM_CHAR;
					end
				end
				S_OPEN: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (!last_delim) begin
							delim_cnt <= delim_cnt + DCNT_W'(1);
							byte_data <= DELIM_CHAR;
						end else if (len_q == '0) begin
							// empty payload goes straight to the closing pair
							state <= S_CLOSE;
							delim_cnt <= '0;
							byte_data <= DELIM_CHAR;
						end else begin
							state <= S_CONTENT;
							byte_cnt <= '0;
							byte_data <= str_buf[7:0];
						end
					end
				end
				S_CONTENT: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (byte_cnt == len_q - LEN_W'(1)) begin
							state <= S_CLOSE;
							delim_cnt <= '0;
							byte_data <= DELIM_CHAR;
						end else begin
							byte_cnt <= byte_cnt + LEN_W'(1);
							byte_data <= str_buf[(byte_cnt + LEN_W'(1)) * 8 +: 8];
						end
					end
				end
				default: begin
					if (byte_done) begin
						if (!last_delim) begin
							delim_cnt <= delim_cnt + DCNT_W'(1);
							byte_req <= 1'b1;
							byte_data <= DELIM_CHAR;
						end else begin
							state <= S_IDLE;
							tx_done <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	// string held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (accept)
			str_buf <= tx_string;
	end

	// done ends a busy period, busy is already low when done shows
	a_done_ends_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy) && !tx_busy
	) else $error("string_framer: tx_done outside a busy period");

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
/*
 * UART receiver, 8N1.
 * Synchronises the line, confirms the start bit at half a bit, samples
 * every data bit at mid-bit and pulses rx_byte_vld at mid stop bit when
 * the stop bit is high. A bad stop bit drops the byte.
 */
`default_nettype none

module uart_rx #(
	parameter int CLK_FREQ = uart_string_pkg::DEF_CLK_FREQ,
	parameter int BAUD_RATE = uart_string_pkg::DEF_BAUD_RATE
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire rx,
	output uart_string_pkg::byte_t rx_byte,
	output logic rx_byte_vld
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0] bit_idx;
	logic bit_end;
	logic sample;

	assign bit_end = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign sample = (state == RX_DATA) && bit_end;

	// two-flop synchroniser plus a delayed copy for edge detection
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (rx_prev && !rx_sync) begin
						state <= RX_START;
						bit_cnt <= '0;
					end
				end
				RX_START: begin
					if (bit_cnt == CNT_W'(HALF_BIT - 1)) begin
						// glitch shorter than half a bit goes back to idle
						state <= rx_sync ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
						bit_idx <= '0;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				default: begin
					if (bit_end) begin
						state <= RX_IDLE;
						bit_cnt <= '0;
						rx_byte_vld <= rx_sync;
					end else begin
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
			endcase
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (sample)
			rx_byte <= {rx_sync, rx_byte[7:1]};
	end

	a_vld_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_byte_vld |=> !rx_byte_vld
	) else $error("uart_rx: rx_byte_vld high on two consecutive cycles");

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
/*
 * UART transmitter, 8N1.
 * A one-cycle byte_req while idle starts a frame; byte_done pulses one
 * cycle after the stop bit ends, and only then may the next request come.
 */
`default_nettype none

module uart_tx #(
	parameter int CLK_FREQ = uart_string_pkg::DEF_CLK_FREQ,
	parameter int BAUD_RATE = uart_string_pkg::DEF_BAUD_RATE
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire byte_req,
	input wire uart_string_pkg::byte_t byte_data,
	output logic byte_done,
	output logic tx
);
	import uart_string_pkg::*;

	localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	logic busy;
	logic [CNT_W-1:0] bit_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	byte_t shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			tx <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_req) begin
					busy <= 1'b1;
					tx <= 1'b0;
					bit_cnt <= '0;
					bit_idx <= '0;
				end
			end else if (bit_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
				bit_cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					// LSB first, then the stop bit
					tx <= (bit_idx == 4'd8) ? 1'b1 : shreg[bit_idx[2:0]];
				end
			end else begin
				bit_cnt <= bit_cnt + CNT_W'(1);
			end
		end
	end

	// byte captured when the frame starts
	always_ff @(posedge sys_clk) begin
		if (byte_req && !busy)
			shreg <= byte_data;
	end

	// the framer must wait for byte_done before the next request
	a_no_req_while_busy: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !busy
	) else $error("uart_tx: byte_req while a frame is in progress");

endmodule

`default_nettype wire

//--- verilog/uart_string_pkg.sv
/*
 * Shared definitions for the UART string link.
 * Holds the character type, the frame delimiter and the default
 * link parameters that the top level hands down to its blocks.
 */
`default_nettype none

package uart_string_pkg;

	// one character on the serial line
	typedef logic [7:0] byte_t;

	// frame delimiter, sent DELIM_COUNT times before and after the payload
	localparam byte_t DELIM_CHAR = 8'h26;
	localparam int DELIM_COUNT = 2;

	// defaults for the top level parameters
	localparam int DEF_CLK_FREQ = 50_000_000;
	localparam int DEF_BAUD_RATE = 115_200;

	// payload capacity in bytes
	localparam int DEF_MAX_LEN = 16;

	// idle bit times before a partial frame is dropped
	localparam int DEF_TIMEOUT_BITS = 20;

endpackage

`default_nettype wire
